// ==== Makefile ====
# Verilator build and run for the QSFP management controller

VERILATOR ?= verilator
TOP       ?= tb_qsfp_ctrl
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/qsfp_i2c_responder.sv ====
// Behavioral I2C master model
// Takes byte read commands with random ready and answers each after 0 to 5 cycles

`timescale 1ns/1ps
`default_nettype none

module qsfp_i2c_responder
   import qsfp_cfg_pkg::*;
(
   input  logic      clk,
   input  logic      rst_i,
   input  logic      cmd_valid_i,
   input  i2c_cmd_t  cmd_data_i,
   output logic      cmd_ready_o,
   output logic      rx_valid_o,
   output mod_byte_t rx_data_o,
   input  logic      rx_ready_i
);

   logic        busy;
   int unsigned delay;
   mod_byte_t   reply;

   initial begin
      cmd_ready_o = 1'b0;
      rx_valid_o  = 1'b0;
      rx_data_o   = '0;
      busy        = 1'b0;
      delay       = 0;
      reply       = '0;
   end

   always @(posedge clk) begin : respond
      logic      cmd_take;
      logic      rx_take;
      mod_byte_t cmd_byte;
      // Handshakes as seen at this edge
      cmd_take = cmd_valid_i && cmd_ready_o;
      rx_take  = rx_valid_o && rx_ready_i;
      cmd_byte = cmd_data_i[7:0];
      #2;
      if (rst_i) begin
         busy        = 1'b0;
         cmd_ready_o = 1'b0;
         rx_valid_o  = 1'b0;
      end else begin
         if (cmd_take) begin
            busy        = 1'b1;
            cmd_ready_o = 1'b0;
            reply       = cmd_byte ^ 8'h5A;
            delay       = $urandom_range(0, 5);
         end else if (rx_take) begin
            rx_valid_o = 1'b0;
            busy       = 1'b0;
         end else if (busy && !rx_valid_o) begin
            if (delay == 0) begin
               rx_valid_o = 1'b1;
               rx_data_o  = reply;
            end else begin
               delay = delay - 1;
            end
         end
         // One byte per command, so no new command while busy
         if (!busy)
            cmd_ready_o = 1'($urandom_range(0, 1));
      end
   end

endmodule

`default_nettype wire

// ==== bench/tb_qsfp_ctrl.sv ====
// Testbench for the QSFP management controller
// Host CSR traffic against a random-latency I2C master, checked by assertions

`timescale 1ns/1ps
`default_nettype none

module tb_qsfp_ctrl
   import qsfp_cfg_pkg::*;
   import qsfp_csr_pkg::*;
();

   // Three sweeps at a generous per-byte bound plus the register tests
   localparam int BYTE_CYCLES_MAX = 80;
   localparam int TIMEOUT_CYCLES  = 3 * SHADOW_BYTES * BYTE_CYCLES_MAX + 4640;

   logic        clk;
   logic        rst_i;
   logic        csr_req_valid_i;
   logic        csr_req_ready_o;
   logic        csr_write_i;
   csr_addr_t   csr_addr_i;
   csr_data_t   csr_wdata_i;
   logic        csr_rsp_valid_o;
   logic        csr_rsp_ready_i;
   csr_data_t   csr_rdata_o;
   logic        cmd_valid_o;
   i2c_cmd_t    cmd_data_o;
   logic        cmd_ready_i;
   logic        rx_valid_i;
   mod_byte_t   rx_data_i;
   logic        rx_ready_o;
   logic        modprsl_i;
   logic        int_qsfp_i;
   logic        modesel_o;
   logic        lpmode_o;
   logic        softreset_qsfpm_o;

   // Expected values and bookkeeping
   csr_data_t   exp_rdata;
   csr_data_t   exp_mask;
   csr_data_t   exp_cfg;
   logic        rsp_write;
   logic        cmd_quiet;
   byte_addr_t  exp_cmd_addr;
   logic        req_open;
   logic        byte_owed;
   int unsigned rsp_count;
   int unsigned cmd_count;
   int unsigned cycle_count = 0;
   csr_data_t   last_rdata;

   qsfp_ctrl_top DUT (
      .clk               (clk),
      .rst_i             (rst_i),
      .csr_req_valid_i   (csr_req_valid_i),
      .csr_req_ready_o   (csr_req_ready_o),
      .csr_write_i       (csr_write_i),
      .csr_addr_i        (csr_addr_i),
      .csr_wdata_i       (csr_wdata_i),
      .csr_rsp_valid_o   (csr_rsp_valid_o),
      .csr_rsp_ready_i   (csr_rsp_ready_i),
      .csr_rdata_o       (csr_rdata_o),
      .cmd_valid_o       (cmd_valid_o),
      .cmd_data_o        (cmd_data_o),
      .cmd_ready_i       (cmd_ready_i),
      .rx_valid_i        (rx_valid_i),
      .rx_data_i         (rx_data_i),
      .rx_ready_o        (rx_ready_o),
      .modprsl_i         (modprsl_i),
      .int_qsfp_i        (int_qsfp_i),
      .modesel_o         (modesel_o),
      .lpmode_o          (lpmode_o),
      .softreset_qsfpm_o (softreset_qsfpm_o)
   );

   qsfp_i2c_responder u_responder (
      .clk         (clk),
      .rst_i       (rst_i),
      .cmd_valid_i (cmd_valid_o),
      .cmd_data_i  (cmd_data_o),
      .cmd_ready_o (cmd_ready_i),
      .rx_valid_o  (rx_valid_i),
      .rx_data_o   (rx_data_i),
      .rx_ready_i  (rx_ready_o)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // --------------------------------------------------
   // Helpers
   // --------------------------------------------------
   task automatic fail_run(input string msg);
      $display("ERROR at %0t ns: %s", $time, msg);
      $display("Verification failed");
      $fatal(1, "stopping at the first error");
   endtask

   // Word w holds module bytes 8w..8w+7, lowest byte in lane 0
   function automatic csr_data_t shadow_word_expected(input int w);
      csr_data_t word;
      word = '0;
      for (int k = 0; k < 8; k++)
         word[8*k +: 8] = 8'(8*w + k) ^ 8'h5A;
      return word;
   endfunction

   // One host access, returns once its response is taken
   task automatic csr_access(input logic write, input csr_addr_t addr, input csr_data_t wdata,
                             input csr_data_t exp, input csr_data_t mask);
      int unsigned target;
      target          = rsp_count + 1;
      exp_rdata       = exp;
      exp_mask        = mask;
      rsp_write       = write;
      csr_req_valid_i = 1'b1;
      csr_write_i     = write;
      csr_addr_i      = addr;
      csr_wdata_i     = wdata;
      while (!csr_req_ready_o) begin
         @(posedge clk);
         #2;
      end
      @(posedge clk);
      #2;
      csr_req_valid_i = 1'b0;
      wait (rsp_count == target);
      #2;
   endtask

   task automatic write_config(input csr_data_t value);
      exp_cfg = value;
      csr_access(1'b1, REG_CONFIG, value, '0, '1);
      csr_access(1'b0, REG_CONFIG, '0, value, '1);
   endtask

   // --------------------------------------------------
   // Monitors and timeout
   // --------------------------------------------------
   always @(posedge clk) begin
      #2;
      csr_rsp_ready_i = 1'($urandom_range(0, 1));
   end

   always @(posedge clk) begin
      if (rst_i) begin
         rsp_count    <= 0;
         cmd_count    <= 0;
         exp_cmd_addr <= '0;
         req_open     <= 1'b0;
         byte_owed    <= 1'b0;
      end else begin
         if (csr_req_valid_i && csr_req_ready_o)
            req_open <= 1'b1;
         if (csr_rsp_valid_o && csr_rsp_ready_i) begin
            rsp_count  <= rsp_count + 1;
            last_rdata <= csr_rdata_o;
            req_open   <= 1'b0;
         end
         // Six bits wide, so byte 63 is followed by byte 0
         if (cmd_valid_o && cmd_ready_i) begin
            cmd_count    <= cmd_count + 1;
            exp_cmd_addr <= exp_cmd_addr + 1'b1;
            byte_owed    <= 1'b1;
         end
         if (rx_valid_i && rx_ready_o)
            byte_owed <= 1'b0;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
         fail_run($sformatf("timeout after %0d cycles, the test did not finish", cycle_count));
   end

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------
   a_rsp_data: assert property (@(posedge clk) disable iff (rst_i)
      csr_rsp_valid_o && csr_rsp_ready_i |-> (csr_rdata_o & exp_mask) == (exp_rdata & exp_mask))
      else fail_run("CSR response data differs from the expected value");

   // One request in flight, ready returns once its response is taken
   a_req_ready: assert property (@(posedge clk) disable iff (rst_i)
      csr_req_ready_o == !req_open && (!csr_rsp_valid_o || req_open))
      else fail_run("CSR request ready or response valid breaks the one-outstanding rule");

   a_pins_follow: assert property (@(posedge clk) disable iff (rst_i)
      csr_rsp_valid_o && csr_rsp_ready_i && rsp_write |=>
         softreset_qsfpm_o == $past(exp_cfg[CFG_SOFTRST_MOD]) &&
         modesel_o == $past(exp_cfg[CFG_MODESEL]) && lpmode_o == $past(exp_cfg[CFG_LPMODE]))
      else fail_run("module pins do not follow the config register");

   a_cmd_seq: assert property (@(posedge clk) disable iff (rst_i)
      cmd_valid_o && cmd_ready_i |->
         cmd_data_o[15:8] == QSFP_DEV_ADDR && cmd_data_o[7:0] == 8'(exp_cmd_addr))
      else fail_run("I2C command has the wrong device or byte address");

   a_cmd_hold: assert property (@(posedge clk) disable iff (rst_i)
      cmd_valid_o && !cmd_ready_i |=> cmd_valid_o && $stable(cmd_data_o))
      else fail_run("I2C command changed while waiting for ready");

   // Byte ready only between an accepted command and its byte
   a_rx_ready: assert property (@(posedge clk) disable iff (rst_i)
      rx_ready_o == byte_owed)
      else fail_run("I2C byte ready outside the wait for a byte");

   a_cmd_quiet: assert property (@(posedge clk) disable iff (rst_i)
      cmd_quiet |-> !cmd_valid_o)
      else fail_run("I2C command issued while polling is stopped");

   // --------------------------------------------------
   // Stimulus
   // --------------------------------------------------
   initial begin
      void'($urandom(32'haa26430d));
      rst_i           = 1'b1;
      csr_req_valid_i = 1'b0;
      csr_write_i     = 1'b0;
      csr_addr_i      = '0;
      csr_wdata_i     = '0;
      csr_rsp_ready_i = 1'b0;
      modprsl_i       = 1'b0;
      int_qsfp_i      = 1'b0;
      exp_rdata       = '0;
      exp_mask        = '0;
      exp_cfg         = CFG_RESET_VALUE;
      rsp_write       = 1'b0;
      cmd_quiet       = 1'b0;
      repeat (4) @(posedge clk);
      #2;
      rst_i = 1'b0;

      // Identifier, read-only behavior and unmapped space
      csr_access(1'b0, REG_ID, '0, QSFP_FEATURE_ID, '1);
      csr_access(1'b1, REG_ID, 64'hFFFF, '0, '1);
      csr_access(1'b0, REG_ID, '0, QSFP_FEATURE_ID, '1);
      csr_access(1'b0, 12'h200, '0, '0, '1);
      csr_access(1'b0, 12'h018, '0, '0, '1);

      // Config readback and module pins
      write_config((64'd1 << CFG_SOFTRST_MOD) | (64'd1 << CFG_MODESEL) |
                   (64'd1 << CFG_LPMODE));
      write_config(64'd1 << CFG_MODESEL);

      // Live status, poller idle with polling off
      modprsl_i  = 1'b1;
      int_qsfp_i = 1'b0;
      csr_access(1'b0, REG_STATUS, '0, 64'h5, 64'h7);
      modprsl_i  = 1'b0;
      int_qsfp_i = 1'b1;
      csr_access(1'b0, REG_STATUS, '0, 64'h6, 64'h7);

      // Two full sweeps with host traffic alongside
      write_config((64'd1 << CFG_POLL_EN) | (64'd1 << CFG_LPMODE));
      csr_access(1'b0, REG_ID, '0, QSFP_FEATURE_ID, '1);
      csr_access(1'b0, 12'h200, '0, '0, '1);
      wait (cmd_count >= 2 * SHADOW_BYTES);
      @(posedge clk);
      #2;

      // Stop polling and wait for the poller to pause
      write_config(64'd1 << CFG_LPMODE);
      do begin
         csr_access(1'b0, REG_STATUS, '0, '0, '0);
      end while (!last_rdata[STS_PAUSED]);
      cmd_quiet = 1'b1;

      for (int w = 0; w < SHADOW_WORDS; w++)
         csr_access(1'b0, SHADOW_BASE + csr_addr_t'(8 * w), '0, shadow_word_expected(w), '1);

      // Controller soft reset holds the poller even with polling on
      write_config((64'd1 << CFG_SOFTRST_CTRL) | (64'd1 << CFG_POLL_EN));
      repeat (50) @(posedge clk);
      #2;
      csr_access(1'b0, REG_STATUS, '0, 64'h4, 64'h4);

      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== source/qsfp_cfg_pkg.sv ====
// QSFP controller configuration package
// Widths, shadow geometry, module device address and poller states

`default_nettype none

package qsfp_cfg_pkg;

   // Host CSR port
   typedef logic [11:0] csr_addr_t;
   typedef logic [63:0] csr_data_t;

   // Module memory and shadow indexing
   typedef logic [7:0]  mod_byte_t;
   typedef logic [5:0]  byte_addr_t;
   typedef logic [2:0]  word_addr_t;

   // Read command to the I2C master, device address in the high byte
   typedef logic [15:0] i2c_cmd_t;

   localparam int SHADOW_BYTES = 64;
   localparam int SHADOW_WORDS = 8;

   // Lower page read address of the module
   localparam mod_byte_t QSFP_DEV_ADDR = 8'hA1;

   typedef enum logic [1:0] {
      IDLE,
      SEND_CMD,
      WAIT_BYTE,
      STORE
   } poll_state_t;

endpackage

`default_nettype wire

// ==== source/qsfp_csr_decoder.sv ====
// Host CSR decoder
// Takes one request at a time, routes it to the registers or the
// shadow RAM, and holds the response until the host takes it

`timescale 1ns/1ps
`default_nettype none

module qsfp_csr_decoder
   import qsfp_cfg_pkg::*;
   import qsfp_csr_pkg::*;
(
   input  logic       clk,
   input  logic       rst_i,

   // Host request and response
   input  logic       csr_req_valid_i,
   output logic       csr_req_ready_o,
   input  logic       csr_write_i,
   input  csr_addr_t  csr_addr_i,
   input  csr_data_t  csr_wdata_i,
   output logic       csr_rsp_valid_o,
   input  logic       csr_rsp_ready_i,
   output csr_data_t  csr_rdata_o,

   // Register block
   output logic       reg_wr_en_o,
   output logic [1:0] reg_sel_o,
   output csr_data_t  reg_wr_data_o,
   input  csr_data_t  reg_rd_data_i,

   // Shadow RAM
   output logic       shadow_rd_en_o,
   output word_addr_t shadow_word_o,
   input  csr_data_t  shadow_rd_data_i
);

   logic      is_reg;
   logic      is_cfg;
   logic      is_shadow;
   logic      req_take;
   logic      rsp_valid_q;
   logic      shadow_wait_q;
   csr_data_t rdata_q;

   // --------------------------------------------------
   // Address decode, word granular
   // --------------------------------------------------
   assign is_cfg    = (csr_addr_i[11:3] == REG_CONFIG[11:3]);
   assign is_reg    = (csr_addr_i[11:3] == REG_ID[11:3]) ||
                      (csr_addr_i[11:3] == REG_STATUS[11:3]) || is_cfg;
   assign is_shadow = (csr_addr_i[11:6] == SHADOW_BASE[11:6]);

   // Busy from acceptance until the response is taken
   assign csr_req_ready_o = !(rsp_valid_q || shadow_wait_q);
   assign req_take        = csr_req_valid_i && csr_req_ready_o;

   assign reg_sel_o      = csr_addr_i[4:3];
   assign reg_wr_data_o  = csr_wdata_i;
   assign reg_wr_en_o    = req_take && csr_write_i && is_cfg;

   assign shadow_rd_en_o = req_take && !csr_write_i && is_shadow;
   assign shadow_word_o  = csr_addr_i[5:3];

   // --------------------------------------------------
   // Response tracking
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst_i) begin
         rsp_valid_q   <= 1'b0;
         shadow_wait_q <= 1'b0;
      end else if (shadow_rd_en_o) begin
         shadow_wait_q <= 1'b1;
      end else if (req_take) begin
         rsp_valid_q <= 1'b1;
      end else if (shadow_wait_q) begin
         // RAM data is out now
         shadow_wait_q <= 1'b0;
         rsp_valid_q   <= 1'b1;
      end else if (rsp_valid_q && csr_rsp_ready_i) begin
         rsp_valid_q <= 1'b0;
      end
   end

   // Writes and unmapped reads answer zero
   always_ff @(posedge clk) begin
      if (req_take)
         rdata_q <= (!csr_write_i && is_reg) ? reg_rd_data_i : '0;
      else if (shadow_wait_q)
         rdata_q <= shadow_rd_data_i;
   end

   assign csr_rsp_valid_o = rsp_valid_q;
   assign csr_rdata_o     = rdata_q;

   a_rsp_hold: assert property (@(posedge clk) disable iff (rst_i)
      csr_rsp_valid_o && !csr_rsp_ready_i |=>
         csr_rsp_valid_o && $stable(csr_rdata_o));

endmodule

`default_nettype wire

// ==== source/qsfp_csr_pkg.sv ====
// QSFP controller register map
// Byte offsets, config and status bit positions, identifier word

`default_nettype none

package qsfp_csr_pkg;

   import qsfp_cfg_pkg::*;

   // --------------------------------------------------
   // Register offsets
   // --------------------------------------------------
   localparam csr_addr_t REG_ID      = 12'h000;
   localparam csr_addr_t REG_STATUS  = 12'h008;
   localparam csr_addr_t REG_CONFIG  = 12'h010;

   // Shadow copy of module bytes 0..63, 0x100 to 0x13F
   localparam csr_addr_t SHADOW_BASE = 12'h100;

   // Read-only identifier word
   localparam csr_data_t QSFP_FEATURE_ID = 64'h5153_4650_4354_0001;

   // --------------------------------------------------
   // Config register bits
   // --------------------------------------------------
   localparam int CFG_SOFTRST_MOD  = 0;
   localparam int CFG_SOFTRST_CTRL = 1;
   localparam int CFG_MODESEL      = 2;
   localparam int CFG_LPMODE       = 3;
   localparam int CFG_POLL_EN      = 4;

   localparam csr_data_t CFG_RESET_VALUE = 64'h0;

   // --------------------------------------------------
   // Status register bits
   // --------------------------------------------------
   localparam int STS_MODPRSL   = 0;
   localparam int STS_INT_QSFP  = 1;
   localparam int STS_PAUSED    = 2;
   localparam int STS_CURR_ADDR = 8;

endpackage

`default_nettype wire

// ==== source/qsfp_csr_regs.sv ====
// Common control and status registers
// Config register drives the module pins, status reflects live inputs

`timescale 1ns/1ps
`default_nettype none

module qsfp_csr_regs
   import qsfp_cfg_pkg::*;
   import qsfp_csr_pkg::*;
(
   input  logic       clk,
   input  logic       rst_i,

   // Access from the decoder
   input  logic       wr_en_i,
   input  logic [1:0] rd_sel_i,
   input  csr_data_t  wr_data_i,
   output csr_data_t  rd_data_o,

   // Live status
   input  logic       modprsl_i,
   input  logic       int_qsfp_i,
   input  logic       paused_i,
   input  byte_addr_t curr_addr_i,

   // Controls
   output logic       modesel_o,
   output logic       lpmode_o,
   output logic       softreset_qsfpm_o,
   output logic       softreset_ctrl_o,
   output logic       poll_en_o
);

   csr_data_t cfg_q;
   csr_data_t status;

   // --------------------------------------------------
   // Config register
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst_i)
         cfg_q <= CFG_RESET_VALUE;
      else if (wr_en_i)
         cfg_q <= wr_data_i;
   end

   assign softreset_qsfpm_o = cfg_q[CFG_SOFTRST_MOD];
   assign softreset_ctrl_o  = cfg_q[CFG_SOFTRST_CTRL];
   assign modesel_o         = cfg_q[CFG_MODESEL];
   assign lpmode_o          = cfg_q[CFG_LPMODE];
   assign poll_en_o         = cfg_q[CFG_POLL_EN];

   // --------------------------------------------------
   // Status word and read mux
   // --------------------------------------------------
   always_comb begin
      status = '0;
      status[STS_MODPRSL]  = modprsl_i;
      status[STS_INT_QSFP] = int_qsfp_i;
      status[STS_PAUSED]   = paused_i;
      status[STS_CURR_ADDR +: $bits(byte_addr_t)] = curr_addr_i;
   end

   // Word select is address bits 4:3
   always_comb begin
      case (rd_sel_i)
         REG_ID[4:3]:     rd_data_o = QSFP_FEATURE_ID;
         REG_STATUS[4:3]: rd_data_o = status;
         REG_CONFIG[4:3]: rd_data_o = cfg_q;
         default:         rd_data_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== source/qsfp_ctrl_top.sv ====
// QSFP management controller top level
// Poller fills the shadow RAM, the decoder serves host CSR accesses

`timescale 1ns/1ps
`default_nettype none

module qsfp_ctrl_top
   import qsfp_cfg_pkg::*;
(
   input  logic      clk,
   input  logic      rst_i,

   // Host CSR port
   input  logic      csr_req_valid_i,
   output logic      csr_req_ready_o,
   input  logic      csr_write_i,
   input  csr_addr_t csr_addr_i,
   input  csr_data_t csr_wdata_i,
   output logic      csr_rsp_valid_o,
   input  logic      csr_rsp_ready_i,
   output csr_data_t csr_rdata_o,

   // I2C master
   output logic      cmd_valid_o,
   output i2c_cmd_t  cmd_data_o,
   input  logic      cmd_ready_i,
   input  logic      rx_valid_i,
   input  mod_byte_t rx_data_i,
   output logic      rx_ready_o,

   // Module pins
   input  logic      modprsl_i,
   input  logic      int_qsfp_i,
   output logic      modesel_o,
   output logic      lpmode_o,
   output logic      softreset_qsfpm_o
);

   logic       ctrl_rst;
   logic       softreset_ctrl;
   logic       poll_en;
   logic       paused;
   byte_addr_t curr_addr;

   logic       sh_wr_en;
   byte_addr_t sh_wr_addr;
   mod_byte_t  sh_wr_data;
   logic       sh_rd_en;
   word_addr_t sh_rd_word;
   csr_data_t  sh_rd_data;

   logic       reg_wr_en;
   logic [1:0] reg_sel;
   csr_data_t  reg_wr_data;
   csr_data_t  reg_rd_data;

   // Controller soft reset only restarts the poller
   assign ctrl_rst = rst_i || softreset_ctrl;

   // --------------------------------------------------
   // Producer
   // --------------------------------------------------
   qsfp_poller u_poller (
      .clk         (clk),
      .rst_i       (ctrl_rst),
      .poll_en_i   (poll_en),
      .cmd_valid_o (cmd_valid_o),
      .cmd_data_o  (cmd_data_o),
      .cmd_ready_i (cmd_ready_i),
      .rx_valid_i  (rx_valid_i),
      .rx_data_i   (rx_data_i),
      .rx_ready_o  (rx_ready_o),
      .wr_en_o     (sh_wr_en),
      .wr_addr_o   (sh_wr_addr),
      .wr_data_o   (sh_wr_data),
      .paused_o    (paused),
      .curr_addr_o (curr_addr)
   );

   qsfp_shadow_ram u_shadow_ram (
      .clk       (clk),
      .wr_en_i   (sh_wr_en),
      .wr_addr_i (sh_wr_addr),
      .wr_data_i (sh_wr_data),
      .rd_en_i   (sh_rd_en),
      .rd_word_i (sh_rd_word),
      .rd_data_o (sh_rd_data)
   );

   // --------------------------------------------------
   // Consumer side
   // --------------------------------------------------
   qsfp_csr_decoder u_decoder (
      .clk              (clk),
      .rst_i            (rst_i),
      .csr_req_valid_i  (csr_req_valid_i),
      .csr_req_ready_o  (csr_req_ready_o),
      .csr_write_i      (csr_write_i),
      .csr_addr_i       (csr_addr_i),
      .csr_wdata_i      (csr_wdata_i),
      .csr_rsp_valid_o  (csr_rsp_valid_o),
      .csr_rsp_ready_i  (csr_rsp_ready_i),
      .csr_rdata_o      (csr_rdata_o),
      .reg_wr_en_o      (reg_wr_en),
      .reg_sel_o        (reg_sel),
      .reg_wr_data_o    (reg_wr_data),
      .reg_rd_data_i    (reg_rd_data),
      .shadow_rd_en_o   (sh_rd_en),
      .shadow_word_o    (sh_rd_word),
      .shadow_rd_data_i (sh_rd_data)
   );

   qsfp_csr_regs u_regs (
      .clk               (clk),
      .rst_i             (rst_i),
      .wr_en_i           (reg_wr_en),
      .rd_sel_i          (reg_sel),
      .wr_data_i         (reg_wr_data),
      .rd_data_o         (reg_rd_data),
      .modprsl_i         (modprsl_i),
      .int_qsfp_i        (int_qsfp_i),
      .paused_i          (paused),
      .curr_addr_i       (curr_addr),
      .modesel_o         (modesel_o),
      .lpmode_o          (lpmode_o),
      .softreset_qsfpm_o (softreset_qsfpm_o),
      .softreset_ctrl_o  (softreset_ctrl),
      .poll_en_o         (poll_en)
   );

endmodule

`default_nettype wire

// ==== source/qsfp_poller.sv ====
// Module poller
// Issues one-byte reads over the I2C command port and forwards each
// returned byte to the shadow RAM, sweeping bytes 0..63 continuously

`timescale 1ns/1ps
`default_nettype none

module qsfp_poller
   import qsfp_cfg_pkg::*;
(
   input  logic       clk,
   input  logic       rst_i,
   input  logic       poll_en_i,

   // I2C master command and byte ports
   output logic       cmd_valid_o,
   output i2c_cmd_t   cmd_data_o,
   input  logic       cmd_ready_i,
   input  logic       rx_valid_i,
   input  mod_byte_t  rx_data_i,
   output logic       rx_ready_o,

   // Shadow write
   output logic       wr_en_o,
   output byte_addr_t wr_addr_o,
   output mod_byte_t  wr_data_o,

   // Status
   output logic       paused_o,
   output byte_addr_t curr_addr_o
);

   poll_state_t state;
   poll_state_t next_state;
   byte_addr_t  curr_addr;
   mod_byte_t   rx_byte;

   // --------------------------------------------------
   // State machine
   // --------------------------------------------------
   always_comb begin
      next_state = state;
      case (state)
         IDLE:      if (poll_en_i) next_state = SEND_CMD;
         // Command stays up until taken, even if polling is switched off
         SEND_CMD:  if (cmd_ready_i) next_state = WAIT_BYTE;
         WAIT_BYTE: if (rx_valid_i) next_state = STORE;
         STORE:     next_state = poll_en_i ? SEND_CMD : IDLE;
         default:   next_state = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state     <= IDLE;
         curr_addr <= '0;
      end else begin
         state <= next_state;
         // Advance once the byte is written, wrap after the last one
         if (state == STORE) begin
            if (curr_addr == byte_addr_t'(SHADOW_BYTES - 1))
               curr_addr <= '0;
            else
               curr_addr <= curr_addr + 1'b1;
         end
      end
   end

   // Returned byte held for the shadow write
   always_ff @(posedge clk) begin
      if (state == WAIT_BYTE && rx_valid_i)
         rx_byte <= rx_data_i;
   end

   // --------------------------------------------------
   // Outputs
   // --------------------------------------------------
   assign cmd_valid_o = (state == SEND_CMD);
   assign cmd_data_o  = {QSFP_DEV_ADDR, 2'b00, curr_addr};
   assign rx_ready_o  = (state == WAIT_BYTE);

   assign wr_en_o     = (state == STORE);
   assign wr_addr_o   = curr_addr;
   assign wr_data_o   = rx_byte;

   assign paused_o    = (state == IDLE);
   assign curr_addr_o = curr_addr;

   // Command held steady while the master stalls
   a_cmd_stable: assert property (@(posedge clk) disable iff (rst_i)
      cmd_valid_o && !cmd_ready_i |=> cmd_valid_o && $stable(cmd_data_o));

   // Accepted byte goes to the shadow in the next cycle
   a_byte_to_shadow: assert property (@(posedge clk) disable iff (rst_i)
      rx_valid_i && rx_ready_o |=> wr_en_o && wr_data_o == $past(rx_data_i));

endmodule

`default_nettype wire

// ==== source/qsfp_shadow_ram.sv ====
// Shadow RAM for the module's lower page
// Byte-lane writes from the poller, registered 64-bit word reads

`timescale 1ns/1ps
`default_nettype none

module qsfp_shadow_ram
   import qsfp_cfg_pkg::*;
(
   input  logic       clk,

   // Byte write port
   input  logic       wr_en_i,
   input  byte_addr_t wr_addr_i,
   input  mod_byte_t  wr_data_i,

   // Word read port
   input  logic       rd_en_i,
   input  word_addr_t rd_word_i,
   output csr_data_t  rd_data_o
);

   csr_data_t  mem [SHADOW_WORDS];

   word_addr_t wr_word;
   logic [2:0] wr_lane;

   // --------------------------------------------------
   // Address split
   // --------------------------------------------------
   // Module byte 8w+k lands in lane k of word w
   assign wr_word = wr_addr_i[5:3];
   assign wr_lane = wr_addr_i[2:0];

   // --------------------------------------------------
   // Write side
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (wr_en_i)
         mem[wr_word][wr_lane*8 +: 8] <= wr_data_i;
   end

   // --------------------------------------------------
   // Read side
   // --------------------------------------------------
   // One cycle latency, output held between reads
   always_ff @(posedge clk) begin
      if (rd_en_i)
         rd_data_o <= mem[rd_word_i];
   end

endmodule

`default_nettype wire

// ==== sources.f ====
source/qsfp_cfg_pkg.sv
source/qsfp_csr_pkg.sv
source/qsfp_poller.sv
source/qsfp_shadow_ram.sv
source/qsfp_csr_regs.sv
source/qsfp_csr_decoder.sv
source/qsfp_ctrl_top.sv
bench/qsfp_i2c_responder.sv
bench/tb_qsfp_ctrl.sv
